// File: design/rv_isa_pkg.sv
// RV32I ISA definitions
`default_nettype none

package rv_isa_pkg;

	localparam int xlen           = 32;
	localparam int reg_addr_width = 5;
	localparam int pc_width       = 12;

	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	// --------------------------------------------------
	// instruction formats with msb first
	typedef struct packed {
		logic [6:0]                funct7;
		logic [reg_addr_width-1:0] rs2;
		logic [reg_addr_width-1:0] rs1;
		logic [2:0]                funct3;
		logic [reg_addr_width-1:0] rd;
		logic [6:0]                opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]               imm;
		logic [reg_addr_width-1:0] rs1;
		logic [2:0]                funct3;
		logic [reg_addr_width-1:0] rd;
		logic [6:0]                opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]                imm_hi;
		logic [reg_addr_width-1:0] rs2;
		logic [reg_addr_width-1:0] rs1;
		logic [2:0]                funct3;
		logic [4:0]                imm_lo;
		logic [6:0]                opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                      imm12;
		logic [5:0]                imm10_5;
		logic [reg_addr_width-1:0] rs2;
		logic [reg_addr_width-1:0] rs1;
		logic [2:0]                funct3;
		logic [3:0]                imm4_1;
		logic                      imm11;
		logic [6:0]                opcode;
	} b_fmt_t;

	typedef struct packed {
		logic                      imm20;
		logic [9:0]                imm10_1;
		logic                      imm11;
		logic [7:0]                imm19_12;
		logic [reg_addr_width-1:0] rd;
		logic [6:0]                opcode;
	} jal_fmt_t;

	typedef union packed {
		r_fmt_t   r_fmt;
		i_fmt_t   i_fmt;
		s_fmt_t   s_fmt;
		b_fmt_t   b_fmt;
		jal_fmt_t jal_fmt;
	} instr_u;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src;
		logic branch;
		logic branch_ne;
		logic jal;
	} ctrl_t;

endpackage

`default_nettype wire

// File: design/rv_pipe_pkg.sv
// Pipeline register types
`default_nettype none

package rv_pipe_pkg;
	import rv_isa_pkg::*;

	typedef struct packed {
		ctrl_t                     ctrl;
		alu_op_e                   alu_op;
		logic [pc_width-1:0]       pc;
		logic [xlen-1:0]           rs1_data;
		logic [xlen-1:0]           rs2_data;
		logic [reg_addr_width-1:0] rs1;
		logic [reg_addr_width-1:0] rs2;
		logic [reg_addr_width-1:0] rd;
		logic [xlen-1:0]           imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [xlen-1:0]           result;
		logic [xlen-1:0]           store_data;
		logic [reg_addr_width-1:0] rd;
	} ex_mem_t;

	typedef struct packed {
		logic                      reg_write;
		logic                      mem_to_reg;
		logic [xlen-1:0]           result;
		logic [xlen-1:0]           load_data;
		logic [reg_addr_width-1:0] rd;
	} mem_wb_t;

	// word address with wdata already in memory byte order
	typedef struct packed {
		logic            read;
		logic            write;
		logic [xlen-3:0] addr;
		logic [xlen-1:0] wdata;
	} dmem_req_t;

	typedef enum logic [1:0] {
		fwd_rf = 2'b00,
		fwd_wb = 2'b01,
		fwd_ex = 2'b10
	} fwd_sel_e;

endpackage

`default_nettype wire

// File: design/fetch_unit.sv
// Instruction fetch stage
`default_nettype none

module fetch_unit import rv_isa_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                stall,
	input  logic                load_hold,
	input  logic                flush_id,
	input  logic                jal_taken,
	input  logic                branch_taken,
	input  logic [pc_width-1:0] jal_target,
	input  logic [pc_width-1:0] branch_target,
	output logic [pc_width-1:0] pc,
	output instr_u              instr,
	output logic [pc_width-3:0] imem_addr,
	input  logic [xlen-1:0]     imem_rdata
);

	logic [pc_width-1:0] fetch_pc;
	logic [pc_width-1:0] next_pc;
	logic [xlen-1:0]     swapped;

	// branch in execute beats jal in decode
	always_comb begin
		if (branch_taken) begin
			next_pc = branch_target;
		end else if (jal_taken) begin
			next_pc = jal_target;
		end else begin
			next_pc = fetch_pc + pc_width'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_pc <= '0;
		end else if (!stall && !load_hold) begin
			fetch_pc <= next_pc;
		end
	end

	assign imem_addr = fetch_pc[pc_width-1:2];

	// memory is big-endian
	assign swapped = {<<8{imem_rdata}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			instr <= '0;
		end else if (!stall) begin
			if (flush_id) begin
				instr <= '0;
			end else if (!load_hold) begin
				instr <= swapped;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && !load_hold) begin
			pc <= fetch_pc;
		end
	end

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
// Instruction decoder
`default_nettype none

module instr_decoder import rv_isa_pkg::*; (
	input  instr_u              instr,
	input  logic [pc_width-1:0] pc,
	output ctrl_t               ctrl,
	output logic [xlen-1:0]     imm,
	output alu_op_e             alu_op,
	output logic [pc_width-1:0] jal_target
);

	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_j;

	function automatic alu_op_e arith_op(input logic [2:0] funct3, input logic sub);
		case (funct3)
			f3_add_sub: arith_op = sub ? alu_sub : alu_add;
			f3_slt:     arith_op = alu_slt;
			f3_or:      arith_op = alu_or;
			f3_and:     arith_op = alu_and;
			default:    arith_op = alu_add;
		endcase
	endfunction

	// --------------------------------------------------
	// sign extended immediates
	assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
	assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
	assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
		instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
	assign imm_j = {{11{instr.jal_fmt.imm20}}, instr.jal_fmt.imm20, instr.jal_fmt.imm19_12,
		instr.jal_fmt.imm11, instr.jal_fmt.imm10_1, 1'b0};

	assign jal_target = pc + imm_j[pc_width-1:0];

	// --------------------------------------------------
	always_comb begin
		ctrl   = '0;
		imm    = imm_i;
		alu_op = alu_add;
		case (instr.r_fmt.opcode)
			op_rtype: begin
				ctrl.reg_write = 1'b1;
				// funct7 bit 5 selects sub
				alu_op = arith_op(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
			end
			op_itype: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				alu_op = arith_op(instr.i_fmt.funct3, 1'b0);
			end
			op_load: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src    = 1'b1;
			end
			op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				imm = imm_s;
			end
			op_branch: begin
				ctrl.branch = 1'b1;
				// funct3 lsb splits beq from bne
				ctrl.branch_ne = instr.b_fmt.funct3[0];
				alu_op = alu_sub;
				imm = imm_b;
			end
			op_jal: begin
				ctrl.jal       = 1'b1;
				ctrl.reg_write = 1'b1;
				imm = imm_j;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Integer register file
`default_nettype none

module reg_file import rv_isa_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [reg_addr_width-1:0] rs1,
	input  logic [reg_addr_width-1:0] rs2,
	input  logic [reg_addr_width-1:0] rd,
	input  logic                      wr_en,
	input  logic [xlen-1:0]           wr_data,
	output logic [xlen-1:0]           rs1_data,
	output logic [xlen-1:0]           rs2_data
);

	logic [xlen-1:0] regs [(1 << reg_addr_width)];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << reg_addr_width); i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && rd != '0) begin
			regs[rd] <= wr_data;
		end
	end

	// writeback bypass so decode sees the value landing this edge
	assign rs1_data = (rs1 == '0) ? '0 :
		(wr_en && rd == rs1) ? wr_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wr_en && rd == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// Forwarding and hazard control
`default_nettype none

module hazard_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic [reg_addr_width-1:0] rs1,
	input  logic [reg_addr_width-1:0] rs2,
	input  id_ex_t                    id_ex,
	input  ex_mem_t                   ex_mem,
	input  mem_wb_t                   mem_wb,
	input  logic                      jal,
	input  logic                      branch_taken,
	output fwd_sel_e                  fwd_a,
	output fwd_sel_e                  fwd_b,
	output logic                      load_hold,
	output logic                      flush_id,
	output logic                      flush_ex
);

	// younger result wins
	function automatic fwd_sel_e fwd_pick(
		input logic [reg_addr_width-1:0] src,
		input ex_mem_t                   mem_stage,
		input mem_wb_t                   wb_stage
	);
		if (mem_stage.ctrl.reg_write && mem_stage.rd != '0 && mem_stage.rd == src) begin
			fwd_pick = fwd_ex;
		end else if (wb_stage.reg_write && wb_stage.rd != '0 && wb_stage.rd == src) begin
			fwd_pick = fwd_wb;
		end else begin
			fwd_pick = fwd_rf;
		end
	endfunction

	assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, mem_wb);
	assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, mem_wb);

	// load data only exists after the memory stage
	assign load_hold = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		(id_ex.rd == rs1 || id_ex.rd == rs2);

	// a held jal stays in decode and redirects next cycle
	assign flush_id = branch_taken || (jal && !load_hold);
	assign flush_ex = branch_taken;

endmodule

`default_nettype wire

// File: design/exec_unit.sv
// Execute stage datapath
`default_nettype none

module exec_unit import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  id_ex_t              id_ex,
	input  fwd_sel_e            fwd_a,
	input  fwd_sel_e            fwd_b,
	input  logic [xlen-1:0]     ex_result,
	input  logic [xlen-1:0]     wb_result,
	output logic [xlen-1:0]     result,
	output logic [xlen-1:0]     store_data,
	output logic                branch_taken,
	output logic [pc_width-1:0] branch_target
);

	logic [xlen-1:0]     op_a;
	logic [xlen-1:0]     op_b;
	logic [xlen-1:0]     rs2_val;
	logic [xlen-1:0]     alu_out;
	logic [pc_width-1:0] pc_plus4;
	logic                zero;

	function automatic logic [xlen-1:0] fwd_mux(
		input fwd_sel_e        sel,
		input logic [xlen-1:0] rf_val,
		input logic [xlen-1:0] mem_val,
		input logic [xlen-1:0] wb_val
	);
		case (sel)
			fwd_ex:  fwd_mux = mem_val;
			fwd_wb:  fwd_mux = wb_val;
			default: fwd_mux = rf_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_result, wb_result);
	assign rs2_val = fwd_mux(fwd_b, id_ex.rs2_data, ex_result, wb_result);
	assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_val;

	always_comb begin
		case (id_ex.alu_op)
			alu_sub: alu_out = op_a - op_b;
			alu_and: alu_out = op_a & op_b;
			alu_or:  alu_out = op_a | op_b;
			alu_slt: alu_out = xlen'($signed(op_a) < $signed(op_b));
			default: alu_out = op_a + op_b;
		endcase
	end

	// branches run through sub, so equality is a zero result
	assign zero         = (alu_out == '0);
	assign branch_taken = id_ex.ctrl.branch && (id_ex.ctrl.branch_ne ? !zero : zero);
	assign branch_target = id_ex.pc + id_ex.imm[pc_width-1:0];

	// jal carries its link value as the result
	assign pc_plus4   = id_ex.pc + pc_width'(4);
	assign result     = id_ex.ctrl.jal ? xlen'(pc_plus4) : alu_out;
	assign store_data = rs2_val;

endmodule

`default_nettype wire

// File: design/rv_core.sv
// Five stage RV32I core
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	output logic [pc_width-3:0] imem_addr,
	input  logic [xlen-1:0]     imem_rdata,
	input  logic                imem_stall,
	input  logic                dmem_stall,
	output dmem_req_t           dmem_req,
	input  logic [xlen-1:0]     dmem_rdata
);

	logic                stall;
	logic                load_hold;
	logic                flush_id;
	logic                flush_ex;
	logic                branch_taken;
	logic [pc_width-1:0] branch_target;
	logic [pc_width-1:0] jal_target;
	logic [pc_width-1:0] id_pc;
	instr_u              id_instr;
	ctrl_t               dec_ctrl;
	logic [xlen-1:0]     dec_imm;
	alu_op_e             dec_alu_op;
	logic [xlen-1:0]     rs1_data;
	logic [xlen-1:0]     rs2_data;
	fwd_sel_e            fwd_a;
	fwd_sel_e            fwd_b;
	logic [xlen-1:0]     exec_result;
	logic [xlen-1:0]     store_data;
	logic [xlen-1:0]     wb_result;
	logic [xlen-1:0]     load_swapped;
	logic [xlen-1:0]     store_swapped;
	id_ex_t              id_ex_d;
	id_ex_t              id_ex;
	ex_mem_t             ex_mem;
	mem_wb_t             mem_wb;

	// either memory freezes the whole pipe
	assign stall = imem_stall || dmem_stall;

	// --------------------------------------------------
	// fetch and decode
	fetch_unit i_fetch_unit (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.load_hold     (load_hold),
		.flush_id      (flush_id),
		.jal_taken     (dec_ctrl.jal),
		.branch_taken  (branch_taken),
		.jal_target    (jal_target),
		.branch_target (branch_target),
		.pc            (id_pc),
		.instr         (id_instr),
		.imem_addr     (imem_addr),
		.imem_rdata    (imem_rdata)
	);

	instr_decoder i_instr_decoder (
		.instr      (id_instr),
		.pc         (id_pc),
		.ctrl       (dec_ctrl),
		.imm        (dec_imm),
		.alu_op     (dec_alu_op),
		.jal_target (jal_target)
	);

	reg_file i_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (id_instr.r_fmt.rs1),
		.rs2      (id_instr.r_fmt.rs2),
		.rd       (mem_wb.rd),
		.wr_en    (mem_wb.reg_write),
		.wr_data  (wb_result),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	hazard_unit i_hazard_unit (
		.rs1          (id_instr.r_fmt.rs1),
		.rs2          (id_instr.r_fmt.rs2),
		.id_ex        (id_ex),
		.ex_mem       (ex_mem),
		.mem_wb       (mem_wb),
		.jal          (dec_ctrl.jal),
		.branch_taken (branch_taken),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.load_hold    (load_hold),
		.flush_id     (flush_id),
		.flush_ex     (flush_ex)
	);

	// --------------------------------------------------
	// ID/EX with a bubble on branch flush or load-use hold
	always_comb begin
		id_ex_d.ctrl     = (flush_ex || load_hold) ? '0 : dec_ctrl;
		id_ex_d.alu_op   = dec_alu_op;
		id_ex_d.pc       = id_pc;
		id_ex_d.rs1_data = rs1_data;
		id_ex_d.rs2_data = rs2_data;
		id_ex_d.rs1      = id_instr.r_fmt.rs1;
		id_ex_d.rs2      = id_instr.r_fmt.rs2;
		id_ex_d.rd       = id_instr.r_fmt.rd;
		id_ex_d.imm      = dec_imm;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.ctrl <= '0;
		end else if (!stall) begin
			id_ex <= id_ex_d;
		end
	end

	exec_unit i_exec_unit (
		.id_ex         (id_ex),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.ex_result     (ex_mem.result),
		.wb_result     (wb_result),
		.result        (exec_result),
		.store_data    (store_data),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	// --------------------------------------------------
	// EX/MEM and data port
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.ctrl <= '0;
		end else if (!stall) begin
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.result     <= exec_result;
			ex_mem.store_data <= store_data;
			ex_mem.rd         <= id_ex.rd;
		end
	end

	// data memory is big-endian too
	assign store_swapped = {<<8{ex_mem.store_data}};
	assign load_swapped  = {<<8{dmem_rdata}};

	assign dmem_req.read  = ex_mem.ctrl.mem_read;
	assign dmem_req.write = ex_mem.ctrl.mem_write;
	assign dmem_req.addr  = ex_mem.result[xlen-1:2];
	assign dmem_req.wdata = store_swapped;

	// --------------------------------------------------
	// MEM/WB and writeback
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.reg_write  <= 1'b0;
			mem_wb.mem_to_reg <= 1'b0;
		end else if (!stall) begin
			mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
			mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
			mem_wb.result     <= ex_mem.result;
			mem_wb.load_data  <= load_swapped;
			mem_wb.rd         <= ex_mem.rd;
		end
	end

	assign wb_result = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.result;

endmodule

`default_nettype wire

// File: dv/tb_rv_core.sv
// RV32I core testbench
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; ();

	logic                clk;
	logic                rst_n = 1'b0;
	logic [pc_width-3:0] imem_addr;
	logic [xlen-1:0]     imem_rdata;
	logic                imem_stall = 1'b0;
	logic                dmem_stall = 1'b0;
	dmem_req_t           dmem_req;
	logic [xlen-1:0]     dmem_rdata;

	logic [xlen-1:0] imem [1 << (pc_width-2)];
	logic [xlen-1:0] dmem [256];
	dmem_req_t       got_q [$];
	dmem_req_t       exp_q [$];
	bit              stall_en = 1'b0;
	int              errors = 0;
	int              checks = 0;

	rv_core i_rv_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.imem_stall (imem_stall),
		.dmem_stall (dmem_stall),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// big-endian combinational memory models
	assign imem_rdata = imem[imem_addr];
	// load data only while the read strobe is up
	assign dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[7:0]] : '0;

	always @(posedge clk) begin
		#1;
		if (stall_en) begin
			imem_stall = ($urandom % 4) == 0;
			dmem_stall = ($urandom % 3) == 0;
		end else begin
			imem_stall = 1'b0;
			dmem_stall = 1'b0;
		end
	end

	// a store counts once, when the whole pipe moves on
	always @(negedge clk) begin
		if (rst_n && dmem_req.write && !dmem_stall) begin
			dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
			if (!imem_stall) begin
				got_q.push_back(dmem_req);
			end
		end
	end

	// --------------------------------------------------
	// hand assembly
	function automatic logic [xlen-1:0] to_big_endian(input logic [xlen-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic logic [xlen-1:0] fill_word(input int unsigned index);
		return (index * 32'h9e3779b1) ^ 32'h5a5a0000;
	endfunction

	function automatic logic [xlen-1:0] rtype_word(input logic [6:0] funct7,
		input logic [2:0] funct3, input int rd, input int rs1, input int rs2);
		return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [xlen-1:0] addi_word(input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
	endfunction

	function automatic logic [xlen-1:0] lw_word(input int rd, input int rs1, input int offset);
		return {12'(offset), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
	endfunction

	function automatic logic [xlen-1:0] sw_word(input int rs2, input int rs1, input int offset);
		logic [11:0] o;
		o = 12'(offset);
		return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], 7'b0100011};
	endfunction

	function automatic logic [xlen-1:0] branch_word(input bit ne, input int rs1, input int rs2,
		input int offset);
		logic [12:0] o;
		o = 13'(offset);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), 2'b00, ne, o[4:1], o[11], 7'b1100011};
	endfunction

	function automatic logic [xlen-1:0] jal_word(input int rd, input int offset);
		logic [20:0] o;
		o = 21'(offset);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
	endfunction

	// --------------------------------------------------
	// compare tasks
	task automatic check_word(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_req(input string name, input dmem_req_t got, input dmem_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s is read=%b write=%b addr=%h wdata=%h,", $time, name,
				got.read, got.write, got.addr, got.wdata);
			$display("    expected read=%b write=%b addr=%h wdata=%h",
				exp.read, exp.write, exp.addr, exp.wdata);
		end
	endtask

	// --------------------------------------------------
	task automatic clear_memories();
		for (int i = 0; i < (1 << (pc_width-2)); i++) begin
			imem[i[pc_width-3:0]] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			dmem[i[7:0]] = fill_word(i);
		end
	endtask

	task automatic put_instr(input int index, input logic [xlen-1:0] word);
		imem[index[pc_width-3:0]] = to_big_endian(word);
	endtask

	task automatic expect_store(input int word, input logic [xlen-1:0] value);
		dmem_req_t req;
		req.read  = 1'b0;
		req.write = 1'b1;
		req.addr  = (xlen-2)'(word);
		req.wdata = to_big_endian(value);
		exp_q.push_back(req);
	endtask

	task automatic hold_reset(input bit with_stalls);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		stall_en = with_stalls;
		got_q.delete();
		exp_q.delete();
		clear_memories();
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic wait_and_compare(input string test_name);
		int cycles;
		cycles = 0;
		while (got_q.size() < exp_q.size() && cycles < 600) begin
			@(posedge clk);
			cycles++;
		end
		if (got_q.size() < exp_q.size()) begin
			errors++;
			$display("%s: only %0d of %0d stores seen after %0d cycles", test_name,
				got_q.size(), exp_q.size(), cycles);
		end
		// shadow stores would show up here
		repeat (20) @(posedge clk);
		check_word({test_name, " store count"}, xlen'(got_q.size()), xlen'(exp_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			check_req($sformatf("%s dmem_req %0d", test_name, i), got_q[i], exp_q[i]);
		end
	endtask

	// --------------------------------------------------
	// directed tests
	task automatic reset_values();
		hold_reset(1'b0);
		put_instr(0, jal_word(0, 0));
		release_reset();
		#5;
		check_word("imem_addr", xlen'(imem_addr), '0);
		check_word("dmem_req.read", xlen'(dmem_req.read), '0);
		check_word("dmem_req.write", xlen'(dmem_req.write), '0);
	endtask

	task automatic forward_alu_chain(input bit with_stalls);
		logic [xlen-1:0] x1;
		logic [xlen-1:0] x2;
		logic [xlen-1:0] x3;
		logic [xlen-1:0] x4;
		logic [xlen-1:0] x5;
		logic [xlen-1:0] x6;
		logic [xlen-1:0] x7;
		logic [xlen-1:0] x8;
		hold_reset(with_stalls);
		put_instr(0, addi_word(1, 0, 100));
		put_instr(1, addi_word(2, 1, -7));
		put_instr(2, rtype_word(7'b0000000, 3'b000, 3, 1, 2));
		put_instr(3, rtype_word(7'b0100000, 3'b000, 4, 3, 1));
		put_instr(4, rtype_word(7'b0000000, 3'b111, 5, 4, 3));
		put_instr(5, rtype_word(7'b0000000, 3'b110, 6, 5, 4));
		put_instr(6, addi_word(8, 0, -20));
		put_instr(7, rtype_word(7'b0000000, 3'b010, 7, 8, 4));
		put_instr(8, sw_word(7, 0, 0));
		put_instr(9, sw_word(3, 0, 4));
		put_instr(10, sw_word(4, 0, 8));
		put_instr(11, sw_word(5, 0, 12));
		put_instr(12, sw_word(6, 0, 16));
		put_instr(13, jal_word(0, 0));
		x1 = 100;
		x2 = x1 - 7;
		x3 = x1 + x2;
		x4 = x3 - x1;
		x5 = x4 & x3;
		x6 = x5 | x4;
		x8 = -20;
		x7 = ($signed(x8) < $signed(x4)) ? 1 : 0;
		expect_store(0, x7);
		expect_store(1, x3);
		expect_store(2, x4);
		expect_store(3, x5);
		expect_store(4, x6);
		release_reset();
		wait_and_compare(with_stalls ? "alu forwarding, stalls" : "alu forwarding");
	endtask

	task automatic load_then_use(input bit with_stalls);
		logic [xlen-1:0] loaded;
		logic [xlen-1:0] sum;
		hold_reset(with_stalls);
		put_instr(0, addi_word(1, 0, 32));
		put_instr(1, lw_word(2, 1, 0));
		put_instr(2, rtype_word(7'b0000000, 3'b000, 3, 2, 1));
		put_instr(3, sw_word(3, 1, 4));
		put_instr(4, lw_word(4, 1, 4));
		put_instr(5, sw_word(4, 1, 8));
		put_instr(6, jal_word(0, 0));
		// core sees the word byte-reversed
		loaded = to_big_endian(dmem[8]);
		sum = loaded + 32;
		expect_store(9, sum);
		expect_store(10, sum);
		release_reset();
		wait_and_compare(with_stalls ? "load-use, stalls" : "load-use");
	endtask

	task automatic branch_and_jump(input bit with_stalls);
		hold_reset(with_stalls);
		put_instr(0, addi_word(1, 0, 5));
		put_instr(1, addi_word(2, 0, 5));
		put_instr(2, branch_word(1'b0, 1, 2, 12));
		put_instr(3, sw_word(1, 0, 0));
		put_instr(4, sw_word(2, 0, 0));
		put_instr(5, branch_word(1'b1, 1, 2, 8));
		put_instr(6, sw_word(1, 0, 4));
		put_instr(7, addi_word(3, 0, 7));
		put_instr(8, branch_word(1'b1, 1, 3, 12));
		put_instr(9, sw_word(3, 0, 8));
		put_instr(10, sw_word(3, 0, 8));
		put_instr(11, branch_word(1'b0, 1, 3, 8));
		put_instr(12, jal_word(5, 12));
		put_instr(13, sw_word(1, 0, 12));
		put_instr(14, sw_word(1, 0, 12));
		put_instr(15, sw_word(5, 0, 16));
		put_instr(16, sw_word(2, 0, 20));
		put_instr(17, jal_word(0, 0));
		expect_store(1, 5);
		// link is the jal address plus 4
		expect_store(4, 12 * 4 + 4);
		expect_store(5, 5);
		release_reset();
		wait_and_compare(with_stalls ? "branches, stalls" : "branches");
	endtask

	// --------------------------------------------------
	initial begin
		void'($urandom(74));
		clear_memories();
		reset_values();
		forward_alu_chain(1'b0);
		load_then_use(1'b0);
		branch_and_jump(1'b0);
		forward_alu_chain(1'b1);
		load_then_use(1'b1);
		branch_and_jump(1'b1);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/exec_unit.sv
design/rv_core.sv
dv/tb_rv_core.sv

// File: Makefile
# Verilator build and run for the rv_core testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_rv_core
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
